// ==== flist.f ====
+incdir+test
source/trace_pkg.sv
source/trace_ex_stage.sv
source/trace_wb_stage.sv
source/trace_retire_buf.sv
source/instr_tracer.sv
test/tb_instr_tracer.sv

// ==== Makefile ====
VERILATOR  ?= verilator
FLIST      := flist.f
TOP        := tb_instr_tracer
RTL_TOP    := instr_tracer
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only -Wall --timing -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
PASS_MSG   := all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_program.svh ====
// Stimulus table for the tracer testbench
// One row per instruction, also the source of its expected record
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [1:0] KIND_ALU   = 2'd0;
localparam logic [1:0] KIND_LOAD  = 2'd1;
localparam logic [1:0] KIND_STORE = 2'd2;

typedef struct packed {
  logic [31:0] pc;
  logic [31:0] instr;
  logic        compressed;
  logic [1:0]  kind;
  logic [4:0]  rd;
  logic [31:0] result;
  logic [31:0] addr;
  logic [31:0] wdata;
} row_t;

localparam int NUM_ROWS = 18;

row_t prog [NUM_ROWS];

// Columns: pc, instr, compressed, kind, rd, result, address, store data
task automatic load_program();
  // Phase with random credit return
  prog[0]  = '{32'h0100, 32'h0400_0093, 1'b0, KIND_ALU,   5'd1, 32'h40,        32'h0,  32'h0};
  prog[1]  = '{32'h0104, 32'h0070_0113, 1'b0, KIND_ALU,   5'd2, 32'h7,         32'h0,  32'h0};
  prog[2]  = '{32'h0108, 32'h0020_a023, 1'b0, KIND_STORE, 5'd0, 32'h0,         32'h40, 32'h7};
  prog[3]  = '{32'h010c, 32'h0000_a183, 1'b0, KIND_LOAD,  5'd3, 32'h7,         32'h40, 32'h0};
  prog[4]  = '{32'h0110, 32'h0000_0185, 1'b1, KIND_ALU,   5'd3, 32'h8,         32'h0,  32'h0};
  prog[5]  = '{32'h0112, 32'h0000_c080, 1'b1, KIND_STORE, 5'd0, 32'h0,         32'h80, 32'h1234};
  prog[6]  = '{32'h0114, 32'h0000_4080, 1'b1, KIND_LOAD,  5'd8, 32'h1234,      32'h80, 32'h0};
  prog[7]  = '{32'h0116, 32'h0021_8233, 1'b0, KIND_ALU,   5'd4, 32'hf,         32'h0,  32'h0};
  prog[8]  = '{32'h011a, 32'h0040_a283, 1'b0, KIND_LOAD,  5'd5, 32'hcafe_0001, 32'h44, 32'h0};
  prog[9]  = '{32'h011e, 32'h0050_a423, 1'b0, KIND_STORE, 5'd0, 32'h0,         32'h48, 32'hcafe_0001};
  // Phase with all credits withheld
  prog[10] = '{32'h0200, 32'h0010_0313, 1'b0, KIND_ALU,   5'd6, 32'h1,         32'h0,  32'h0};
  prog[11] = '{32'h0204, 32'h0013_0313, 1'b0, KIND_ALU,   5'd6, 32'h2,         32'h0,  32'h0};
  prog[12] = '{32'h0208, 32'h0060_a023, 1'b0, KIND_STORE, 5'd0, 32'h0,         32'h40, 32'h2};
  prog[13] = '{32'h020c, 32'h0000_a383, 1'b0, KIND_LOAD,  5'd7, 32'h2,         32'h40, 32'h0};
  prog[14] = '{32'h0210, 32'h0000_0385, 1'b1, KIND_ALU,   5'd7, 32'h3,         32'h0,  32'h0};
  prog[15] = '{32'h0212, 32'h0063_8433, 1'b0, KIND_ALU,   5'd8, 32'h5,         32'h0,  32'h0};
  prog[16] = '{32'h0216, 32'h0080_a223, 1'b0, KIND_STORE, 5'd0, 32'h0,         32'h44, 32'h5};
  prog[17] = '{32'h021a, 32'h0040_a483, 1'b0, KIND_LOAD,  5'd9, 32'h5,         32'h44, 32'h0};
endtask

`endif

// ==== test/tb_instr_tracer.sv ====
// Testbench for the instruction tracer: table-driven core model,
// credit-returning consumer and in-order record checks
`default_nettype none

module tb_instr_tracer;
  import trace_pkg::*;

  localparam int unsigned FIFO_DEPTH  = 4;
  localparam int unsigned MAX_CREDITS = 2;
  localparam int          WAIT_LIMIT  = 200;

  `include "tb_program.svh"

  logic        clk_i;
  logic        rst_n;
  decode_if_t  dec_i;
  ex_obs_t     ex_i;
  wb_obs_t     wb_i;
  logic        credit_i;
  trace_rec_t  rec_o;
  logic        rec_valid_o;
  logic        overflow_o;

  trace_rec_t  exp_q [$];
  int unsigned due_q [$];
  int unsigned edge_cnt;
  int unsigned last_due;
  int          outstanding;
  int          n_checks;
  int          n_errors;
  int          n_received;
  logic        hold_credits;
  integer      seed = 94;

  instr_tracer #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MAX_CREDITS (MAX_CREDITS)
  ) u_dut (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .dec_i       (dec_i),
    .ex_i        (ex_i),
    .wb_i        (wb_i),
    .credit_i    (credit_i),
    .rec_o       (rec_o),
    .rec_valid_o (rec_valid_o),
    .overflow_o  (overflow_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #10 clk_i = ~clk_i;
    end
  end

  // Rising edges since reset release, the reference for stamps
  always @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  // ------------------------------------------------------------
  // Expected values and checks
  // ------------------------------------------------------------
  function automatic trace_rec_t expected_record(row_t r, cycle_t stamp);
    trace_rec_t rec;
    rec            = '0;
    rec.stamp      = stamp;
    rec.pc         = r.pc;
    rec.instr      = r.instr;
    rec.compressed = r.compressed;
    if (r.kind != KIND_STORE) begin
      rec.rd.valid = 1'b1;
      rec.rd.addr  = r.rd;
      rec.rd.data  = r.result;
    end
    if (r.kind != KIND_ALU) begin
      rec.mem.valid = 1'b1;
      rec.mem.write = (r.kind == KIND_STORE);
      rec.mem.addr  = r.addr;
      rec.mem.wdata = (r.kind == KIND_STORE) ? r.wdata : 32'h0;
    end
    return rec;
  endfunction

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_record(trace_rec_t got);
    trace_rec_t exp;
    if (exp_q.size() == 0) begin
      n_errors++;
      $display("Record with pc %h arrived when no record was expected", got.pc);
      return;
    end
    exp = exp_q.pop_front();
    check_value("rec_o.stamp", got.stamp, exp.stamp);
    check_value("rec_o.pc", got.pc, exp.pc);
    check_value("rec_o.instr", got.instr, exp.instr);
    check_value("rec_o.compressed", 32'(got.compressed), 32'(exp.compressed));
    check_value("rec_o.rd.valid", 32'(got.rd.valid), 32'(exp.rd.valid));
    check_value("rec_o.rd.addr", 32'(got.rd.addr), 32'(exp.rd.addr));
    check_value("rec_o.rd.data", got.rd.data, exp.rd.data);
    check_value("rec_o.mem.valid", 32'(got.mem.valid), 32'(exp.mem.valid));
    check_value("rec_o.mem.write", 32'(got.mem.write), 32'(exp.mem.write));
    check_value("rec_o.mem.addr", got.mem.addr, exp.mem.addr);
    check_value("rec_o.mem.wdata", got.mem.wdata, exp.mem.wdata);
  endtask

  // ------------------------------------------------------------
  // Core model: decode row c, execute row c-1, writeback row c-2
  // ------------------------------------------------------------
  task automatic drive_cycle(int c, int first, int last, int n_keep);
    row_t r;
    dec_i = '0;
    ex_i  = '0;
    wb_i  = '0;
    if (c <= last) begin
      r              = prog[c];
      dec_i.valid    = 1'b1;
      dec_i.decoding = 1'b1;
      dec_i.pc       = r.pc;
      dec_i.instr    = r.instr;
      dec_i.compressed = r.compressed;
      if (c - first < n_keep) begin
        exp_q.push_back(expected_record(r, edge_cnt));
      end
    end
    if (c - 1 >= first && c - 1 <= last) begin
      r             = prog[c-1];
      ex_i.ex_valid = 1'b1;
      if (r.kind == KIND_ALU) begin
        ex_i.reg_we    = 1'b1;
        ex_i.reg_addr  = r.rd;
        ex_i.reg_wdata = r.result;
      end else begin
        ex_i.data_req   = 1'b1;
        ex_i.data_gnt   = 1'b1;
        ex_i.data_we    = (r.kind == KIND_STORE);
        ex_i.data_addr  = r.addr;
        // Loads put junk on the store bus, the record must show zero
        ex_i.data_wdata = (r.kind == KIND_STORE) ? r.wdata : 32'hdead_beef;
      end
    end
    if (c - 2 >= first && c - 2 <= last) begin
      r             = prog[c-2];
      wb_i.wb_valid = 1'b1;
      if (r.kind == KIND_LOAD) begin
        wb_i.reg_we    = 1'b1;
        wb_i.reg_addr  = r.rd;
        wb_i.reg_wdata = r.result;
      end
    end
  endtask

  task automatic run_rows(int first, int last, int n_keep);
    for (int c = first; c <= last + 2; c++) begin
      @(negedge clk_i);
      drive_cycle(c, first, last, n_keep);
    end
    @(negedge clk_i);
    dec_i = '0;
    ex_i  = '0;
    wb_i  = '0;
  endtask

  task automatic wait_records(logic with_credits);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || (with_credits && due_q.size() != 0)) && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0 || (with_credits && due_q.size() != 0)) begin
      n_errors++;
      $display("Timeout: %0d records missing, %0d credits unreturned after %0d cycles",
               exp_q.size(), due_q.size(), WAIT_LIMIT);
    end
  endtask

  task automatic wait_overflow();
    int n;
    n = 0;
    while (overflow_o !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge clk_i);
      n++;
    end
    if (overflow_o !== 1'b1) begin
      n_errors++;
      $display("Timeout: overflow_o did not rise while credits were withheld");
    end
  endtask

  // Consumer takes records and returns credits after a random delay
  initial begin : consumer
    int unsigned due;
    credit_i = 1'b0;
    forever begin
      @(negedge clk_i);
      credit_i = 1'b0;
      if (rst_n && rec_valid_o) begin
        check_record(rec_o);
        n_received++;
        outstanding++;
        if (outstanding > int'(MAX_CREDITS)) begin
          n_errors++;
          $display("Consumer holds %0d records, more than the %0d credits it gave",
                   outstanding, MAX_CREDITS);
        end
        due = edge_cnt + ($unsigned($random(seed)) % 6);
        if (due < last_due) begin
          due = last_due;
        end
        last_due = due;
        due_q.push_back(due);
      end
      if (!hold_credits && due_q.size() != 0 && due_q[0] <= edge_cnt) begin
        void'(due_q.pop_front());
        credit_i = 1'b1;
        outstanding--;
      end
    end
  end

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin
    rst_n        = 1'b0;
    dec_i        = '0;
    ex_i         = '0;
    wb_i         = '0;
    hold_credits = 1'b0;
    outstanding  = 0;
    last_due     = 0;
    n_checks     = 0;
    n_errors     = 0;
    n_received   = 0;
    load_program();
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n = 1'b1;
    check_value("rec_valid_o", 32'(rec_valid_o), 32'h0);
    check_value("overflow_o", 32'(overflow_o), 32'h0);

    // Bursts no longer than the FIFO, so nothing can be lost
    run_rows(0, 3, 4);
    wait_records(1'b0);
    run_rows(4, 7, 4);
    wait_records(1'b0);
    run_rows(8, 9, 2);
    wait_records(1'b1);
    check_value("overflow_o", 32'(overflow_o), 32'h0);
    check_value("records received", n_received, 32'd10);

    // No credits come back, so only FIFO plus credits survive
    hold_credits = 1'b1;
    run_rows(10, 17, FIFO_DEPTH + MAX_CREDITS);
    wait_overflow();
    hold_credits = 1'b0;
    wait_records(1'b1);
    // Quiet period to catch stray records
    repeat (20) @(negedge clk_i);
    check_value("records received", n_received, 32'(10 + FIFO_DEPTH + MAX_CREDITS));
    check_value("overflow_o", 32'(overflow_o), 32'h1);

    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/instr_tracer.sv ====
// Instruction-retire tracer top level
// Chain of execute slot, writeback slot and retire buffer
`default_nettype none

module instr_tracer #(
  parameter int unsigned FIFO_DEPTH  = 4,
  parameter int unsigned MAX_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::decode_if_t dec_i,
  input  trace_pkg::ex_obs_t    ex_i,
  input  trace_pkg::wb_obs_t    wb_i,
  input  logic                  credit_i,
  output trace_pkg::trace_rec_t rec_o,
  output logic                  rec_valid_o,
  output logic                  overflow_o
);
  import trace_pkg::*;

  trace_rec_t ex_rec;
  trace_rec_t ret_rec;
  logic       ex_move;
  logic       ret_push;

  trace_ex_stage u_ex (
    .clk_i     (clk_i),
    .rst_n     (rst_n),
    .dec_i     (dec_i),
    .ex_i      (ex_i),
    .ex_rec_o  (ex_rec),
    .ex_move_o (ex_move)
  );

  trace_wb_stage u_wb (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .ex_rec_i   (ex_rec),
    .ex_move_i  (ex_move),
    .wb_i       (wb_i),
    .ret_rec_o  (ret_rec),
    .ret_push_o (ret_push)
  );

  // Back-pressure ends here, the core is never stalled
  trace_retire_buf #(
    .FIFO_DEPTH  (FIFO_DEPTH),
    .MAX_CREDITS (MAX_CREDITS)
  ) u_buf (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .rec_i       (ret_rec),
    .push_i      (ret_push),
    .credit_i    (credit_i),
    .rec_o       (rec_o),
    .rec_valid_o (rec_valid_o),
    .overflow_o  (overflow_o)
  );

endmodule

`default_nettype wire

// ==== source/trace_retire_buf.sv ====
// In-order record FIFO with credit-paced output
// and a sticky overflow flag
`default_nettype none

module trace_retire_buf #(
  parameter int unsigned FIFO_DEPTH  = 4,
  parameter int unsigned MAX_CREDITS = 2
) (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::trace_rec_t rec_i,
  input  logic                  push_i,
  input  logic                  credit_i,
  output trace_pkg::trace_rec_t rec_o,
  output logic                  rec_valid_o,
  output logic                  overflow_o
);
  import trace_pkg::*;

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int unsigned CRD_W = $clog2(MAX_CREDITS + 1);

  trace_rec_t       mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CRD_W-1:0] credits_q;
  logic             full;
  logic             wr_en;
  logic             send;

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign wr_en = push_i && !full;
  // A record goes out only against a credit
  assign send  = (count_q != '0) && (credits_q != '0);

  // ------------------------------------------------------------
  // Pointers, fill level, credits and overflow
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q    <= '0;
      rd_ptr_q    <= '0;
      count_q     <= '0;
      credits_q   <= CRD_W'(MAX_CREDITS);
      rec_valid_o <= 1'b0;
      overflow_o  <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (send) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q     <= count_q + CNT_W'(wr_en) - CNT_W'(send);
      credits_q   <= credits_q + CRD_W'(credit_i) - CRD_W'(send);
      rec_valid_o <= send;
      // Sticky until reset once a record is lost
      if (push_i && full) begin
        overflow_o <= 1'b1;
      end
    end
  end

  // Record storage and output register
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= rec_i;
    end
    if (send) begin
      rec_o <= mem_q[rd_ptr_q];
    end
  end

  // Consumer never returns more credits than it was sent records
  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_n)
    credits_q <= CRD_W'(MAX_CREDITS));

endmodule

`default_nettype wire

// ==== source/trace_wb_stage.sv ====
// Writeback slot of the tracer: load write-back merge
// and hand-off of completed records
`default_nettype none

module trace_wb_stage (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::trace_rec_t ex_rec_i,
  input  logic                  ex_move_i,
  input  trace_pkg::wb_obs_t    wb_i,
  output trace_pkg::trace_rec_t ret_rec_o,
  output logic                  ret_push_o
);
  import trace_pkg::*;

  trace_rec_t slot_q;
  trace_rec_t slot_merged;
  logic       slot_valid_q;
  logic       is_load;

  // A read access in the record marks a load
  assign is_load = slot_q.mem.valid && !slot_q.mem.write;

  always_comb begin
    slot_merged = slot_q;
    if (wb_i.reg_we && is_load) begin
      slot_merged.rd.valid = 1'b1;
      slot_merged.rd.addr  = wb_i.reg_addr;
      slot_merged.rd.data  = wb_i.reg_wdata;
    end
  end

  // Record retires in the wb_valid cycle with the load data included
  assign ret_rec_o  = slot_merged;
  assign ret_push_o = slot_valid_q && wb_i.wb_valid;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= 1'b0;
    end else if (ex_move_i) begin
      slot_valid_q <= 1'b1;
    end else if (ret_push_o) begin
      slot_valid_q <= 1'b0;
    end
  end

  // A load write-back may come before wb_valid, so keep the merge
  always_ff @(posedge clk_i) begin
    if (ex_move_i) begin
      slot_q <= ex_rec_i;
    end else if (slot_valid_q) begin
      slot_q <= slot_merged;
    end
  end

  // Writeback writes only come from loads that passed execute
  a_wb_write_is_load : assert property (@(posedge clk_i) disable iff (!rst_n)
    wb_i.reg_we |-> (slot_valid_q && is_load));

endmodule

`default_nettype wire

// ==== source/trace_ex_stage.sv ====
// Execute slot of the tracer: record creation at decode,
// cycle stamp and merging of execute results
`default_nettype none

module trace_ex_stage (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::decode_if_t dec_i,
  input  trace_pkg::ex_obs_t    ex_i,
  output trace_pkg::trace_rec_t ex_rec_o,
  output logic                  ex_move_o
);
  import trace_pkg::*;

  cycle_t     cycle_q;
  trace_rec_t slot_q;
  trace_rec_t slot_merged;
  logic       slot_valid_q;
  logic       dec_new;
  logic       data_acc;

  // Only legal instructions that are really decoded get a record
  assign dec_new  = dec_i.valid && dec_i.decoding && !dec_i.illegal;
  assign data_acc = ex_i.data_req && ex_i.data_gnt;

  // Edges since reset release
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      cycle_q <= '0;
    end else begin
      cycle_q <= cycle_q + cycle_t'(1);
    end
  end

  // ------------------------------------------------------------
  // Merge of execute results into the held record
  // ------------------------------------------------------------
  always_comb begin
    slot_merged = slot_q;
    if (ex_i.reg_we) begin
      slot_merged.rd.valid = 1'b1;
      slot_merged.rd.addr  = ex_i.reg_addr;
      slot_merged.rd.data  = ex_i.reg_wdata;
    end
    if (data_acc) begin
      slot_merged.mem.valid = 1'b1;
      slot_merged.mem.write = ex_i.data_we;
      slot_merged.mem.addr  = ex_i.data_addr;
      slot_merged.mem.wdata = ex_i.data_we ? ex_i.data_wdata : '0;
    end
  end

  // Results of the leaving cycle travel with the record
  assign ex_rec_o  = slot_merged;
  assign ex_move_o = slot_valid_q && ex_i.ex_valid;

  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      slot_valid_q <= 1'b0;
    end else if (dec_new) begin
      slot_valid_q <= 1'b1;
    end else if (ex_move_o) begin
      slot_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_new) begin
      slot_q.stamp      <= cycle_q;
      slot_q.pc         <= dec_i.pc;
      slot_q.instr      <= dec_i.instr;
      slot_q.compressed <= dec_i.compressed;
      slot_q.rd         <= '0;
      slot_q.mem        <= '0;
    end else if (slot_valid_q) begin
      slot_q <= slot_merged;
    end
  end

  // Execute results always belong to an instruction in the slot
  a_ex_result_has_slot : assert property (@(posedge clk_i) disable iff (!rst_n)
    (ex_i.reg_we || data_acc) |-> slot_valid_q);

  // One instruction per stage, so decode only refills a leaving slot
  a_no_slot_overwrite : assert property (@(posedge clk_i) disable iff (!rst_n)
    (dec_new && slot_valid_q) |-> ex_move_o);

endmodule

`default_nettype wire

// ==== source/trace_pkg.sv ====
// Widths, core observation structs and the trace record
// shared by all tracer stages
`default_nettype none

package trace_pkg;

  // ------------------------------------------------------------
  // Widths with a meaning
  // ------------------------------------------------------------
  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [31:0] cycle_t;

  // One integer register write
  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    xlen_t     data;
  } reg_wr_t;

  // One data memory access, wdata stays zero for reads
  typedef struct packed {
    logic  valid;
    logic  write;
    xlen_t addr;
    xlen_t wdata;
  } mem_acc_t;

  // One retired instruction as it leaves the tracer
  typedef struct packed {
    cycle_t   stamp;
    xlen_t    pc;
    xlen_t    instr;
    logic     compressed;
    reg_wr_t  rd;
    mem_acc_t mem;
  } trace_rec_t;

  // ------------------------------------------------------------
  // Observation points on the core
  // ------------------------------------------------------------
  typedef struct packed {
    logic  valid;
    logic  decoding;
    logic  illegal;
    xlen_t pc;
    xlen_t instr;
    logic  compressed;
  } decode_if_t;

  typedef struct packed {
    logic      ex_valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
    logic      data_req;
    logic      data_gnt;
    logic      data_we;
    xlen_t     data_addr;
    xlen_t     data_wdata;
  } ex_obs_t;

  typedef struct packed {
    logic      wb_valid;
    logic      reg_we;
    reg_addr_t reg_addr;
    xlen_t     reg_wdata;
  } wb_obs_t;

endpackage

`default_nettype wire
